// ==== Makefile ====
SIM        = verilator
TOP        = tb_eth_loopback
FILELIST   = eth_loopback.f
SIM_FLAGS  = --binary --timing --assert
LINT_FLAGS = --lint-only --timing --assert
BUILD_DIR  = obj_dir
LOG        = sim.log
PASS_MSG   = All tests passed!

.PHONY: all lint sim clean

all: sim

lint:
	$(SIM) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(SIM) $(SIM_FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR) -o $(TOP)
	./$(BUILD_DIR)/$(TOP) 2>&1 | tee $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== eth_fifo.sv ====
`default_nettype none

module eth_fifo #(
     parameter type payload_t = logic
    ,parameter int  depth     = 4
) (
     input  wire            clk
    ,input  wire            rst

    ,input  wire            push
    ,input  wire payload_t  push_data
    ,output logic           full

    ,input  wire            pop
    ,output payload_t       pop_data
    ,output logic           empty
);

    localparam int ptr_w = (depth > 1) ? $clog2(depth) : 1;

    payload_t           mem [depth];
    logic [ptr_w-1:0]   wr_ptr;
    logic [ptr_w-1:0]   rd_ptr;
    logic [ptr_w:0]     count;
    logic               do_push;
    logic               do_pop;

    assign full  = (count == (ptr_w+1)'(depth));
    assign empty = (count == '0);

    assign do_push = push && !full;
    assign do_pop  = pop && !empty;

    assign pop_data = mem[rd_ptr];

    always_ff @(posedge clk) begin
        if (do_push) begin
            mem[wr_ptr] <= push_data;
        end
    end

    // Pointers wrap explicitly so that depths other than a power of two work.
    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end
        else begin
            if (do_push) begin
                wr_ptr <= (wr_ptr == ptr_w'(depth - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (do_pop) begin
                rd_ptr <= (rd_ptr == ptr_w'(depth - 1)) ? '0 : rd_ptr + 1'b1;
            end
            case ({do_push, do_pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

endmodule

`default_nettype wire

// ==== eth_loopback.f ====
eth_pkg.sv
loopback_pkg.sv
eth_fifo.sv
eth_rx_decode.sv
eth_swap_execute.sv
eth_tx_result.sv
eth_loopback_top.sv
eth_loopback_props.sv
tb_eth_loopback.sv

// ==== eth_loopback_props.sv ====
`default_nettype none

module eth_loopback_props (
     input  wire                                 clk
    ,input  wire                                 rst
    ,input  wire                                 engine_mac_tx_val
    ,input  wire  [eth_pkg::mac_interface_w-1:0] engine_mac_tx_data
    ,input  wire                                 engine_mac_tx_last
    ,input  wire  [eth_pkg::mac_padbytes_w-1:0]  engine_mac_tx_padbytes
    ,input  wire                                 mac_engine_tx_rdy
);

    timeunit 1ns;
    timeprecision 1ps;

    // A stalled beat stays offered and unchanged until the MAC takes it.
    tx_hold_while_stalled: assert property (
        @(posedge clk) disable iff (rst)
        (engine_mac_tx_val && !mac_engine_tx_rdy) |=>
            (engine_mac_tx_val && $stable(engine_mac_tx_data)
             && $stable(engine_mac_tx_last) && $stable(engine_mac_tx_padbytes))
    ) else $error("tx beat changed while the MAC held tx_rdy low");

    tx_pad_only_on_last: assert property (
        @(posedge clk) disable iff (rst)
        (engine_mac_tx_val && !engine_mac_tx_last) |-> (engine_mac_tx_padbytes == '0)
    ) else $error("tx padbytes nonzero on a beat that is not last");

    tx_idle_after_reset: assert property (
        @(posedge clk) $fell(rst) |-> !engine_mac_tx_val
    ) else $error("tx_val high in the first cycle after reset");

endmodule

`default_nettype wire

// ==== eth_loopback_top.sv ====
`default_nettype none

module eth_loopback_top (
     input  wire                                 clk
    ,input  wire                                 rst

    ,input  wire                                 mac_engine_rx_val
    ,input  wire  [eth_pkg::mac_interface_w-1:0] mac_engine_rx_data
    ,input  wire                                 mac_engine_rx_last
    ,input  wire  [eth_pkg::mac_padbytes_w-1:0]  mac_engine_rx_padbytes
    ,output logic                                engine_mac_rx_rdy

    ,output logic                                engine_mac_tx_val
    ,output logic [eth_pkg::mac_interface_w-1:0] engine_mac_tx_data
    ,output logic                                engine_mac_tx_last
    ,output logic [eth_pkg::mac_padbytes_w-1:0]  engine_mac_tx_padbytes
    ,input  wire                                 mac_engine_tx_rdy

    ,output logic [loopback_pkg::count_w-1:0]    frames_echoed
    ,output logic [loopback_pkg::count_w-1:0]    frames_dropped
);

    logic                                beat_push;
    loopback_pkg::beat_t                 beat_push_data;
    logic                                beat_full;
    logic                                beat_pop;
    loopback_pkg::beat_t                 beat_pop_data;
    logic                                beat_empty;

    logic                                verdict_push;
    loopback_pkg::verdict_e              verdict_push_data;
    logic                                verdict_full;
    logic                                verdict_pop;
    loopback_pkg::verdict_e              verdict_pop_data;
    logic                                verdict_empty;

    logic                                out_val;
    logic [eth_pkg::mac_interface_w-1:0] out_data;
    logic                                out_last;
    logic [eth_pkg::mac_padbytes_w-1:0]  out_padbytes;
    logic                                out_take;

    eth_rx_decode eth_rx_decode_inst (
         .clk                    (clk)
        ,.rst                    (rst)
        ,.mac_engine_rx_val      (mac_engine_rx_val)
        ,.mac_engine_rx_data     (mac_engine_rx_data)
        ,.mac_engine_rx_last     (mac_engine_rx_last)
        ,.mac_engine_rx_padbytes (mac_engine_rx_padbytes)
        ,.engine_mac_rx_rdy      (engine_mac_rx_rdy)
        ,.beat_push              (beat_push)
        ,.beat_data              (beat_push_data)
        ,.beat_full              (beat_full)
        ,.verdict_push           (verdict_push)
        ,.verdict                (verdict_push_data)
        ,.verdict_full           (verdict_full)
    );

    eth_fifo #(
         .payload_t (loopback_pkg::beat_t)
        ,.depth     (loopback_pkg::beat_fifo_depth)
    ) beat_fifo_inst (
         .clk       (clk)
        ,.rst       (rst)
        ,.push      (beat_push)
        ,.push_data (beat_push_data)
        ,.full      (beat_full)
        ,.pop       (beat_pop)
        ,.pop_data  (beat_pop_data)
        ,.empty     (beat_empty)
    );

    eth_fifo #(
         .payload_t (loopback_pkg::verdict_e)
        ,.depth     (loopback_pkg::verdict_fifo_depth)
    ) verdict_fifo_inst (
         .clk       (clk)
        ,.rst       (rst)
        ,.push      (verdict_push)
        ,.push_data (verdict_push_data)
        ,.full      (verdict_full)
        ,.pop       (verdict_pop)
        ,.pop_data  (verdict_pop_data)
        ,.empty     (verdict_empty)
    );

    eth_swap_execute eth_swap_execute_inst (
         .clk            (clk)
        ,.rst            (rst)
        ,.verdict        (verdict_pop_data)
        ,.verdict_empty  (verdict_empty)
        ,.verdict_pop    (verdict_pop)
        ,.beat_data      (beat_pop_data)
        ,.beat_empty     (beat_empty)
        ,.beat_pop       (beat_pop)
        ,.out_val        (out_val)
        ,.out_data       (out_data)
        ,.out_last       (out_last)
        ,.out_padbytes   (out_padbytes)
        ,.out_take       (out_take)
        ,.frames_dropped (frames_dropped)
    );

    eth_tx_result eth_tx_result_inst (
         .clk                    (clk)
        ,.rst                    (rst)
        ,.out_val                (out_val)
        ,.out_data               (out_data)
        ,.out_last               (out_last)
        ,.out_padbytes           (out_padbytes)
        ,.out_take               (out_take)
        ,.engine_mac_tx_val      (engine_mac_tx_val)
        ,.engine_mac_tx_data     (engine_mac_tx_data)
        ,.engine_mac_tx_last     (engine_mac_tx_last)
        ,.engine_mac_tx_padbytes (engine_mac_tx_padbytes)
        ,.mac_engine_tx_rdy      (mac_engine_tx_rdy)
        ,.frames_echoed          (frames_echoed)
    );

endmodule

`default_nettype wire

// ==== eth_loopback_vectors.txt ====
// Columns: kind, then three hex fields.
// kind 0 = mode (0 tx ready, 1 random tx stalls, 2 tx held until rx stalls), 0, 0.
// kind 1 = rx beat and kind 2 = expected tx beat, each as data, last, padbytes.
// kind 3 = expected frames_echoed, frames_dropped, 0. kind f = end of vectors.
0 0 0 0
1 0200000000010a1b2c3d4e5f08004500 0 0
1 00540000400040010000c0a80001c0a8 1 4
2 0a1b2c3d4e5f02000000000108004500 0 0
2 00540000400040010000c0a80001c0a8 1 4
3 1 0 0
1 ffffffffffff6655443322110806abcd 1 2
2 665544332211ffffffffffff0806abcd 1 2
3 2 0 0
1 0200000000020a1b2c3d4e5f08000000 1 0
1 0200000000010a1b2c3d4e5f08000000 1 3
3 2 2 0
0 1 0 0
1 020000000001deadbeef000186dd6000 0 0
1 11112222333344445555666677778888 1 0
1 123456789abc0a1b2c3d4e5f08000000 1 0
1 ffffffffffff00112233445508004500 0 0
1 0102030405060708090a0b0c0d0e0f10 1 8
2 deadbeef000102000000000186dd6000 0 0
2 11112222333344445555666677778888 1 0
2 001122334455ffffffffffff08004500 0 0
2 0102030405060708090a0b0c0d0e0f10 1 8
3 4 3 0
0 2 0 0
1 0200000000015000000000010800aa01 1 0
1 0200000000015000000000020800aa02 1 0
1 0200000000015000000000030800aa03 1 0
1 0200000000015000000000040800aa04 1 0
1 0200000000015000000000050800aa05 1 0
1 0200000000015000000000060800aa06 1 0
1 0200000000015000000000070800aa07 1 0
2 5000000000010200000000010800aa01 1 0
2 5000000000020200000000010800aa02 1 0
2 5000000000030200000000010800aa03 1 0
2 5000000000040200000000010800aa04 1 0
2 5000000000050200000000010800aa05 1 0
2 5000000000060200000000010800aa06 1 0
2 5000000000070200000000010800aa07 1 0
3 b 3 0
f 0 0 0

// ==== eth_pkg.sv ====
`default_nettype none

package eth_pkg;

    localparam int mac_interface_w = 128;
    localparam int mac_padbytes_w  = 4;
    localparam int mac_addr_w      = 48;

    // Byte 0 is the most significant byte of a beat.
    // The destination address occupies bytes 0 to 5 and the source address bytes 6 to 11.
    localparam int dst_addr_msb = mac_interface_w - 1;
    localparam int src_addr_msb = mac_interface_w - 1 - mac_addr_w;

    localparam logic [mac_addr_w-1:0] local_mac_addr = 48'h02_00_00_00_00_01;
    localparam logic [mac_addr_w-1:0] broadcast_addr = {mac_addr_w{1'b1}};

    // Destination, source and EtherType.
    localparam int min_header_bytes = 14;

endpackage

`default_nettype wire

// ==== eth_rx_decode.sv ====
`default_nettype none

module eth_rx_decode (
     input  wire                                 clk
    ,input  wire                                 rst

    ,input  wire                                 mac_engine_rx_val
    ,input  wire  [eth_pkg::mac_interface_w-1:0] mac_engine_rx_data
    ,input  wire                                 mac_engine_rx_last
    ,input  wire  [eth_pkg::mac_padbytes_w-1:0]  mac_engine_rx_padbytes
    ,output logic                                engine_mac_rx_rdy

    ,output logic                                beat_push
    ,output loopback_pkg::beat_t                 beat_data
    ,input  wire                                 beat_full

    ,output logic                                verdict_push
    ,output loopback_pkg::verdict_e              verdict
    ,input  wire                                 verdict_full
);

    localparam int beat_bytes = eth_pkg::mac_interface_w / 8;
    localparam int bytes_w    = eth_pkg::mac_padbytes_w + 1;

    logic                               rx_fire;
    logic                               sof;
    logic                               addr_ok_reg;
    logic                               addr_ok_now;
    logic                               frame_addr_ok;
    logic                               frame_short;
    logic [eth_pkg::mac_addr_w-1:0]     dst_addr;
    logic [bytes_w-1:0]                 valid_bytes;

    // A verdict may be due on any beat, so both FIFOs must have room.
    assign engine_mac_rx_rdy = !beat_full && !verdict_full;
    assign rx_fire = mac_engine_rx_val && engine_mac_rx_rdy;

    assign dst_addr = mac_engine_rx_data[eth_pkg::dst_addr_msb -: eth_pkg::mac_addr_w];
    assign addr_ok_now = (dst_addr == eth_pkg::local_mac_addr)
                      || (dst_addr == eth_pkg::broadcast_addr);
    assign frame_addr_ok = sof ? addr_ok_now : addr_ok_reg;

    // Only a frame that ends on its first beat can be shorter than a header.
    assign valid_bytes = bytes_w'(beat_bytes) - {1'b0, mac_engine_rx_padbytes};
    assign frame_short = sof && mac_engine_rx_last
                      && (valid_bytes < bytes_w'(eth_pkg::min_header_bytes));

    always_ff @(posedge clk) begin
        if (rst) begin
            sof         <= 1'b1;
            addr_ok_reg <= 1'b0;
        end
        else if (rx_fire) begin
            sof <= mac_engine_rx_last;
            if (sof) begin
                addr_ok_reg <= addr_ok_now;
            end
        end
    end

    assign beat_push = rx_fire;

    always_comb begin
        beat_data.data     = mac_engine_rx_data;
        beat_data.last     = mac_engine_rx_last;
        beat_data.padbytes = mac_engine_rx_padbytes;
    end

    assign verdict_push = rx_fire && mac_engine_rx_last;
    assign verdict = (frame_addr_ok && !frame_short) ? loopback_pkg::keep : loopback_pkg::drop;

endmodule

`default_nettype wire

// ==== eth_swap_execute.sv ====
`default_nettype none

module eth_swap_execute (
     input  wire                                 clk
    ,input  wire                                 rst

    ,input  wire loopback_pkg::verdict_e         verdict
    ,input  wire                                 verdict_empty
    ,output logic                                verdict_pop

    ,input  wire loopback_pkg::beat_t            beat_data
    ,input  wire                                 beat_empty
    ,output logic                                beat_pop

    ,output logic                                out_val
    ,output logic [eth_pkg::mac_interface_w-1:0] out_data
    ,output logic                                out_last
    ,output logic [eth_pkg::mac_padbytes_w-1:0]  out_padbytes
    ,input  wire                                 out_take

    ,output logic [loopback_pkg::count_w-1:0]    frames_dropped
);

    typedef enum logic [1:0] {
        idle    = 2'd0,
        forward = 2'd1,
        discard = 2'd2
    } state_e;

    state_e state_reg;
    state_e state_next;
    logic   first_reg;
    logic   incr_drop;

    always_ff @(posedge clk) begin
        if (rst) begin
            state_reg      <= idle;
            first_reg      <= 1'b0;
            frames_dropped <= '0;
        end
        else begin
            state_reg <= state_next;
            if (verdict_pop) begin
                first_reg <= 1'b1;
            end
            else if (beat_pop) begin
                first_reg <= 1'b0;
            end
            if (incr_drop) begin
                frames_dropped <= frames_dropped + 1'b1;
            end
        end
    end

    // The verdict arrives after the whole frame is stored, so beats never run dry mid-frame.
    always_comb begin
        state_next  = state_reg;
        verdict_pop = 1'b0;
        beat_pop    = 1'b0;
        out_val     = 1'b0;
        incr_drop   = 1'b0;
        case (state_reg)
            idle: begin
                if (!verdict_empty) begin
                    verdict_pop = 1'b1;
                    state_next  = (verdict == loopback_pkg::keep) ? forward : discard;
                end
            end
            forward: begin
                out_val = !beat_empty;
                if (out_val && out_take) begin
                    beat_pop = 1'b1;
                    if (beat_data.last) begin
                        state_next = idle;
                    end
                end
            end
            discard: begin
                if (!beat_empty) begin
                    beat_pop = 1'b1;
                    if (beat_data.last) begin
                        incr_drop  = 1'b1;
                        state_next = idle;
                    end
                end
            end
            default: state_next = idle;
        endcase
    end

    always_comb begin
        out_data = beat_data.data;
        if (first_reg) begin
            out_data[eth_pkg::dst_addr_msb -: eth_pkg::mac_addr_w] =
                beat_data.data[eth_pkg::src_addr_msb -: eth_pkg::mac_addr_w];
            out_data[eth_pkg::src_addr_msb -: eth_pkg::mac_addr_w] =
                beat_data.data[eth_pkg::dst_addr_msb -: eth_pkg::mac_addr_w];
        end
    end

    assign out_last     = beat_data.last;
    assign out_padbytes = beat_data.padbytes;

endmodule

`default_nettype wire

// ==== eth_tx_result.sv ====
`default_nettype none

module eth_tx_result (
     input  wire                                 clk
    ,input  wire                                 rst

    ,input  wire                                 out_val
    ,input  wire  [eth_pkg::mac_interface_w-1:0] out_data
    ,input  wire                                 out_last
    ,input  wire  [eth_pkg::mac_padbytes_w-1:0]  out_padbytes
    ,output logic                                out_take

    ,output logic                                engine_mac_tx_val
    ,output logic [eth_pkg::mac_interface_w-1:0] engine_mac_tx_data
    ,output logic                                engine_mac_tx_last
    ,output logic [eth_pkg::mac_padbytes_w-1:0]  engine_mac_tx_padbytes
    ,input  wire                                 mac_engine_tx_rdy

    ,output logic [loopback_pkg::count_w-1:0]    frames_echoed
);

    logic tx_fire;

    assign tx_fire = engine_mac_tx_val && mac_engine_tx_rdy;

    // The register can load whenever it is empty or its beat leaves this cycle.
    assign out_take = !engine_mac_tx_val || mac_engine_tx_rdy;

    always_ff @(posedge clk) begin
        if (rst) begin
            engine_mac_tx_val <= 1'b0;
            frames_echoed     <= '0;
        end
        else begin
            if (out_take) begin
                engine_mac_tx_val <= out_val;
            end
            if (tx_fire && engine_mac_tx_last) begin
                frames_echoed <= frames_echoed + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (out_take && out_val) begin
            engine_mac_tx_data     <= out_data;
            engine_mac_tx_last     <= out_last;
            engine_mac_tx_padbytes <= out_padbytes;
        end
    end

endmodule

`default_nettype wire

// ==== loopback_pkg.sv ====
`default_nettype none

package loopback_pkg;

    localparam int beat_fifo_depth    = 16;
    localparam int verdict_fifo_depth = 4;
    localparam int count_w            = 16;

    typedef enum logic {
        keep = 1'b0,
        drop = 1'b1
    } verdict_e;

    typedef struct packed {
        logic [eth_pkg::mac_interface_w-1:0] data;
        logic                                last;
        logic [eth_pkg::mac_padbytes_w-1:0]  padbytes;
    } beat_t;

endpackage

`default_nettype wire

// ==== tb_eth_loopback.sv ====
`default_nettype none

module tb_eth_loopback;

    timeunit 1ns;
    timeprecision 1ps;

    localparam int vec_words  = 256;
    localparam int wait_limit = 2000;

    logic                                clk;
    logic                                rst;
    logic                                mac_engine_rx_val;
    logic [eth_pkg::mac_interface_w-1:0] mac_engine_rx_data;
    logic                                mac_engine_rx_last;
    logic [eth_pkg::mac_padbytes_w-1:0]  mac_engine_rx_padbytes;
    logic                                engine_mac_rx_rdy;
    logic                                engine_mac_tx_val;
    logic [eth_pkg::mac_interface_w-1:0] engine_mac_tx_data;
    logic                                engine_mac_tx_last;
    logic [eth_pkg::mac_padbytes_w-1:0]  engine_mac_tx_padbytes;
    logic                                mac_engine_tx_rdy;
    logic [loopback_pkg::count_w-1:0]    frames_echoed;
    logic [loopback_pkg::count_w-1:0]    frames_dropped;

    logic [eth_pkg::mac_interface_w-1:0] vec_mem [vec_words];
    loopback_pkg::beat_t                 rx_q [$];
    loopback_pkg::beat_t                 exp_q [$];
    loopback_pkg::beat_t                 exp_beat;
    logic [1:0]                          test_mode;
    int                                  stall_cycles;
    int                                  stall_base;
    logic [31:0]                         lfsr_state;

    eth_loopback_top eth_loopback_top_inst (
         .clk                    (clk)
        ,.rst                    (rst)
        ,.mac_engine_rx_val      (mac_engine_rx_val)
        ,.mac_engine_rx_data     (mac_engine_rx_data)
        ,.mac_engine_rx_last     (mac_engine_rx_last)
        ,.mac_engine_rx_padbytes (mac_engine_rx_padbytes)
        ,.engine_mac_rx_rdy      (engine_mac_rx_rdy)
        ,.engine_mac_tx_val      (engine_mac_tx_val)
        ,.engine_mac_tx_data     (engine_mac_tx_data)
        ,.engine_mac_tx_last     (engine_mac_tx_last)
        ,.engine_mac_tx_padbytes (engine_mac_tx_padbytes)
        ,.mac_engine_tx_rdy      (mac_engine_tx_rdy)
        ,.frames_echoed          (frames_echoed)
        ,.frames_dropped         (frames_dropped)
    );

    bind eth_loopback_top eth_loopback_props eth_loopback_props_inst (
         .clk                    (clk)
        ,.rst                    (rst)
        ,.engine_mac_tx_val      (engine_mac_tx_val)
        ,.engine_mac_tx_data     (engine_mac_tx_data)
        ,.engine_mac_tx_last     (engine_mac_tx_last)
        ,.engine_mac_tx_padbytes (engine_mac_tx_padbytes)
        ,.mac_engine_tx_rdy      (mac_engine_tx_rdy)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    task automatic report_failure(input string what);
        $display("%s", what);
        $display("Test failures found");
        $fatal(1, "simulation stopped");
    endtask

    task automatic check_value(input string name, input logic [127:0] actual,
                               input logic [127:0] expected);
        if (actual !== expected) begin
            report_failure($sformatf("CHECK FAILED at %0d ns: %s is %h, expected %h",
                                     $time, name, actual, expected));
        end
    endtask

    // Fibonacci LFSR with taps 32, 22, 2 and 1.
    function automatic logic [31:0] lfsr_next(input logic [31:0] state);
        logic feedback;
        feedback = state[31] ^ state[21] ^ state[1] ^ state[0];
        return {state[30:0], feedback};
    endfunction

    function automatic loopback_pkg::beat_t make_beat(input int rec);
        loopback_pkg::beat_t beat;
        beat.data     = vec_mem[rec + 1];
        beat.last     = vec_mem[rec + 2][0];
        beat.padbytes = vec_mem[rec + 3][eth_pkg::mac_padbytes_w-1:0];
        return beat;
    endfunction

    // Mode 2 keeps tx stalled until the engine has pushed back on rx at least once.
    always @(posedge clk) begin
        case (test_mode)
            2'd1: begin
                lfsr_state = lfsr_next(lfsr_state);
                mac_engine_tx_rdy <= lfsr_state[0];
            end
            2'd2:    mac_engine_tx_rdy <= (stall_cycles != stall_base);
            default: mac_engine_tx_rdy <= 1'b1;
        endcase
    end

    always @(negedge clk) begin
        if (mac_engine_rx_val && !engine_mac_rx_rdy) begin
            stall_cycles++;
        end
    end

    // Both signals settle half a cycle before the edge on which the beat moves.
    always @(negedge clk) begin
        if (!rst && engine_mac_tx_val && mac_engine_tx_rdy) begin
            if (exp_q.size() == 0) begin
                report_failure("The engine sent a tx beat that no vector expects.");
            end
            else begin
                exp_beat = exp_q.pop_front();
                check_value("engine_mac_tx_data", engine_mac_tx_data, exp_beat.data);
                check_value("engine_mac_tx_last", 128'(engine_mac_tx_last),
                            128'(exp_beat.last));
                check_value("engine_mac_tx_padbytes", 128'(engine_mac_tx_padbytes),
                            128'(exp_beat.padbytes));
            end
        end
    end

    task automatic send_beat(input loopback_pkg::beat_t beat);
        int waited;
        mac_engine_rx_val      <= 1'b1;
        mac_engine_rx_data     <= beat.data;
        mac_engine_rx_last     <= beat.last;
        mac_engine_rx_padbytes <= beat.padbytes;
        waited = 0;
        @(negedge clk);
        while (!engine_mac_rx_rdy) begin
            if (waited >= wait_limit) begin
                report_failure("The engine never accepted an rx beat.");
            end
            waited++;
            @(negedge clk);
        end
        @(posedge clk);
    endtask

    // Every frame ends as either echoed or dropped, so the sum tells when the test is done.
    task automatic run_test(input logic [loopback_pkg::count_w-1:0] exp_echoed,
                            input logic [loopback_pkg::count_w-1:0] exp_dropped);
        int waited;
        int exp_total;
        exp_total = int'(exp_echoed) + int'(exp_dropped);
        while (rx_q.size() > 0) begin
            send_beat(rx_q.pop_front());
        end
        mac_engine_rx_val <= 1'b0;
        if (test_mode == 2'd2 && stall_cycles == stall_base) begin
            report_failure("engine_mac_rx_rdy never fell while tx was held low.");
        end
        waited = 0;
        @(negedge clk);
        while (int'(frames_echoed) + int'(frames_dropped) < exp_total
               || exp_q.size() != 0) begin
            if (waited >= wait_limit) begin
                report_failure("The expected frames were not all echoed or dropped in time.");
            end
            waited++;
            @(negedge clk);
        end
        check_value("frames_echoed", 128'(frames_echoed), 128'(exp_echoed));
        check_value("frames_dropped", 128'(frames_dropped), 128'(exp_dropped));
        @(posedge clk);
    endtask

    initial begin
        int                               rec;
        logic                             done;
        logic [3:0]                       kind;
        rst                    = 1'b1;
        mac_engine_rx_val      = 1'b0;
        mac_engine_rx_data     = '0;
        mac_engine_rx_last     = 1'b0;
        mac_engine_rx_padbytes = '0;
        mac_engine_tx_rdy      = 1'b1;
        test_mode              = 2'd0;
        stall_cycles           = 0;
        stall_base             = 0;
        lfsr_state             = 32'h1ca8f21b;
        $readmemh("eth_loopback_vectors.txt", vec_mem);

        repeat (5) @(posedge clk);
        rst <= 1'b0;
        @(negedge clk);
        check_value("engine_mac_tx_val", 128'(engine_mac_tx_val), 128'(1'b0));
        check_value("engine_mac_rx_rdy", 128'(engine_mac_rx_rdy), 128'(1'b1));
        check_value("frames_echoed", 128'(frames_echoed), 128'(0));
        check_value("frames_dropped", 128'(frames_dropped), 128'(0));
        @(posedge clk);

        rec  = 0;
        done = 1'b0;
        while (!done) begin
            if (rec + 3 >= vec_words) begin
                report_failure("The vector file has no end record.");
            end
            kind = vec_mem[rec][3:0];
            case (kind)
                4'h0: begin
                    test_mode  <= vec_mem[rec + 1][1:0];
                    stall_base <= stall_cycles;
                end
                4'h1: rx_q.push_back(make_beat(rec));
                4'h2: exp_q.push_back(make_beat(rec));
                4'h3: run_test(vec_mem[rec + 1][loopback_pkg::count_w-1:0],
                               vec_mem[rec + 2][loopback_pkg::count_w-1:0]);
                4'hf: done = 1'b1;
                default: report_failure($sformatf("Vector record %0d has an unknown kind.",
                                                  rec / 4));
            endcase
            rec = rec + 4;
        end

        if (exp_q.size() != 0 || rx_q.size() != 0) begin
            report_failure("Beats after the last counter record were never exchanged.");
        end
        else begin
            $display("All tests passed!");
            $finish;
        end
    end

endmodule

`default_nettype wire
